// File: hdl/rv_decode_defines.svh
`ifndef RV_DECODE_DEFINES_SVH
`define RV_DECODE_DEFINES_SVH

// RV64I major opcodes
`define OP_LUI      7'b0110111
`define OP_AUIPC    7'b0010111
`define OP_INTIMM   7'b0010011
`define OP_INTREG   7'b0110011
`define OP_INTIMMW  7'b0011011
`define OP_INTREGW  7'b0111011
`define OP_JAL      7'b1101111
`define OP_JALR     7'b1100111
`define OP_BRANCH   7'b1100011
`define OP_LOAD     7'b0000011
`define OP_STORE    7'b0100011
`define OP_FENCE    7'b0001111
`define OP_ENVCSR   7'b1110011

// ALU ops follow funct3, EQ sits above that range
`define ALU_ADDSUB  4'd0
`define ALU_SLT     4'd2
`define ALU_SLTU    4'd3
`define ALU_EQ      4'd8

`define ALUOPT_ADD  1'b0

// Operand 1 source
`define D_OPR1_RS1  2'd0
`define D_OPR1_PC   2'd1
`define D_OPR1_ZERO 2'd2
`define D_OPR1_ZIMM 2'd3

// Operand 2 source
`define D_OPR2_RS2  2'd0
`define D_OPR2_IMM  2'd1
`define D_OPR2_4    2'd2

// Branch type and target base
`define BT_NONE     2'd0
`define BT_JAL      2'd1
`define BT_JALR     2'd2
`define BT_BCOND    2'd3
`define BB_PC       1'b0
`define BB_RS1      1'b1

// Branch conditions as encoded in funct3
`define BC_EQ       3'b000
`define BC_NE       3'b001
`define BC_LT       3'b100
`define BC_GE       3'b101
`define BC_LTU      3'b110
`define BC_GEU      3'b111

// Pipe classes
`define OT_INT      3'd0
`define OT_BRANCH   3'd1
`define OT_LOAD     3'd2
`define OT_STORE    3'd3
`define OT_FENCE    3'd4
`define OT_TRAP     3'd5

// Machine trap causes
`define MCAUSE_ILLEGALI 4'd2
`define MCAUSE_BRKPOINT 4'd3
`define MCAUSE_ECALLMM  4'd11

`endif

// File: hdl/rv_decode_pkg.sv
package rv_decode_pkg;

    typedef logic [31:0] instr_t;
    typedef logic [63:0] xlen_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [3:0]  alu_op_t;
    typedef logic [2:0]  op_class_t;
    typedef logic [3:0]  cause_t;

    // Fetched word with its address
    typedef struct packed {
        instr_t instr;
        xlen_t  pc;
    } fetch_t;

    // Decode record handed to the issue pipes
    typedef struct packed {
        // Integer pipe controls
        alu_op_t    op;
        logic       option;
        logic       truncate;
        logic [1:0] br_type;
        logic       br_neg;       // Branch taken when ALU result is 0
        logic       br_base_src;
        logic       br_inj_pc;
        // Load/store pipe controls
        logic       mem_sign;
        logic [1:0] mem_width;
        // Trap pipe controls
        logic [1:0] csr_op;
        logic       mret;
        logic       intr;
        cause_t     cause;
        // Common fields
        op_class_t  op_type;
        logic [1:0] operand1;
        logic [1:0] operand2;
        xlen_t      imm;
        logic       legal;
        logic       wb_en;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        reg_idx_t   rd;
        logic       fencei;
    } decoded_t;

endpackage

// File: hdl/fetch_latch.sv
`timescale 1ns/1ns

module fetch_latch (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  instr_valid,
    input  logic                  flush,
    input  rv_decode_pkg::fetch_t fetch_in,
    output rv_decode_pkg::fetch_t fetch_q,
    output logic                  fetch_valid
);

    // Word and PC only move on a strobe
    always_ff @(posedge clk) begin
        if (instr_valid) begin
            fetch_q <= fetch_in;
        end
    end

    // Flush drops anything offered in the same cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fetch_valid <= 1'b0;
        end else if (flush) begin
            fetch_valid <= 1'b0;
        end else begin
            fetch_valid <= instr_valid;
        end
    end

endmodule

// File: hdl/instr_decoder.sv
`timescale 1ns/1ns
`include "rv_decode_defines.svh"

module instr_decoder (
    input  rv_decode_pkg::instr_t   instr,
    output rv_decode_pkg::decoded_t dec
);

    logic [6:0] funct7;
    logic [2:0] funct3;
    logic [6:0] opcode;

    rv_decode_pkg::xlen_t imm_i;
    rv_decode_pkg::xlen_t imm_s;
    rv_decode_pkg::xlen_t imm_b;
    rv_decode_pkg::xlen_t imm_u;
    rv_decode_pkg::xlen_t imm_j;

    assign funct7 = instr[31:25];
    assign funct3 = instr[14:12];
    assign opcode = instr[6:0];

    // Immediates sign extended from bit 31
    assign imm_i = {{52{instr[31]}}, instr[31:20]};
    assign imm_s = {{52{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{52{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {{32{instr[31]}}, instr[31:12], 12'b0};
    assign imm_j = {{44{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        dec = '0;
        dec.rs1 = instr[19:15];
        dec.rs2 = instr[24:20];
        dec.rd = instr[11:7];

        case (opcode)
            `OP_LUI, `OP_AUIPC: begin
                dec.op_type = `OT_INT;
                dec.op = `ALU_ADDSUB;
                dec.option = `ALUOPT_ADD;
                dec.imm = imm_u;
                dec.operand1 = (opcode == `OP_LUI) ? `D_OPR1_ZERO : `D_OPR1_PC;
                dec.operand2 = `D_OPR2_IMM;
                dec.wb_en = 1'b1;
                dec.legal = 1'b1;
            end
            `OP_INTIMM, `OP_INTIMMW: begin
                dec.op_type = `OT_INT;
                dec.op = {1'b0, funct3};
                // srai vs srli
                dec.option = (funct3 == 3'b101) ? funct7[5] : 1'b0;
                dec.truncate = (opcode == `OP_INTIMMW);
                dec.imm = imm_i;
                dec.operand1 = `D_OPR1_RS1;
                dec.operand2 = `D_OPR2_IMM;
                dec.wb_en = 1'b1;
                dec.legal = 1'b1;
                if (opcode == `OP_INTIMM) begin
                    // 6-bit shamt on RV64
                    if (funct3 == 3'b001 && funct7[6:1] != 6'd0)
                        dec.legal = 1'b0;
                    if (funct3 == 3'b101 && (funct7[6] || funct7[4:1] != 4'd0))
                        dec.legal = 1'b0;
                end else begin
                    if (funct3 == 3'b001 && funct7 != 7'd0)
                        dec.legal = 1'b0;
                    else if (funct3 == 3'b101 && (funct7[6] || funct7[4:0] != 5'd0))
                        dec.legal = 1'b0;
                    else if (funct3 != 3'b000 && funct3 != 3'b001 && funct3 != 3'b101)
                        dec.legal = 1'b0;
                end
            end
            `OP_INTREG, `OP_INTREGW: begin
                dec.op_type = `OT_INT;
                dec.op = {1'b0, funct3};
                dec.option = (funct3 == 3'b000 || funct3 == 3'b101) ? funct7[5] : 1'b0;
                dec.truncate = (opcode == `OP_INTREGW);
                dec.operand1 = `D_OPR1_RS1;
                dec.operand2 = `D_OPR2_RS2;
                dec.wb_en = 1'b1;
                dec.legal = 1'b1;
                if (funct3 == 3'b000 || funct3 == 3'b101) begin
                    if (funct7[6] || funct7[4:0] != 5'd0)
                        dec.legal = 1'b0;
                end else if (funct7 != 7'd0) begin
                    dec.legal = 1'b0;
                end else if (opcode == `OP_INTREGW && funct3 != 3'b001) begin
                    dec.legal = 1'b0;
                end
            end
            `OP_JAL, `OP_JALR: begin
                // Link value is PC + 4
                dec.op_type = `OT_BRANCH;
                dec.op = `ALU_ADDSUB;
                dec.option = `ALUOPT_ADD;
                dec.operand1 = `D_OPR1_PC;
                dec.operand2 = `D_OPR2_4;
                dec.wb_en = 1'b1;
                dec.legal = 1'b1;
                if (opcode == `OP_JAL) begin
                    dec.imm = imm_j;
                    dec.br_type = `BT_JAL;
                    dec.br_base_src = `BB_PC;
                end else begin
                    dec.imm = imm_i;
                    dec.br_type = `BT_JALR;
                    dec.br_base_src = `BB_RS1;
                    dec.br_inj_pc = 1'b1;
                end
            end
            `OP_BRANCH: begin
                dec.op_type = `OT_BRANCH;
                dec.imm = imm_b;
                dec.operand1 = `D_OPR1_RS1;
                dec.operand2 = `D_OPR2_RS2;
                dec.br_type = `BT_BCOND;
                dec.br_base_src = `BB_PC;
                dec.legal = 1'b1;
                case (funct3)
                    `BC_EQ:  dec.op = `ALU_EQ;
                    `BC_NE:  {dec.op, dec.br_neg} = {`ALU_EQ, 1'b1};
                    `BC_LT:  dec.op = `ALU_SLT;
                    `BC_GE:  {dec.op, dec.br_neg} = {`ALU_SLT, 1'b1};
                    `BC_LTU: dec.op = `ALU_SLTU;
                    `BC_GEU: {dec.op, dec.br_neg} = {`ALU_SLTU, 1'b1};
                    default: dec.legal = 1'b0;
                endcase
            end
            `OP_LOAD, `OP_STORE: begin
                dec.mem_sign = funct3[2];
                dec.mem_width = funct3[1:0];
                dec.operand1 = `D_OPR1_RS1;
                dec.legal = 1'b1;
                if (opcode == `OP_LOAD) begin
                    dec.op_type = `OT_LOAD;
                    dec.operand2 = `D_OPR2_IMM;
                    dec.imm = imm_i;
                    dec.wb_en = 1'b1;
                    dec.legal = (funct3 != 3'b111);
                end else begin
                    dec.op_type = `OT_STORE;
                    dec.operand2 = `D_OPR2_RS2;
                    dec.imm = imm_s;
                    dec.legal = !funct3[2];
                end
            end
            `OP_FENCE: begin
                dec.op_type = `OT_FENCE;
                if (instr[31:28] == 4'd0 && instr[19:7] == 13'd0) begin
                    dec.legal = 1'b1;
                end else if (instr[31:7] == 25'h0000020) begin
                    dec.fencei = 1'b1;
                    dec.legal = 1'b1;
                end
            end
            `OP_ENVCSR: begin
                dec.op_type = `OT_TRAP;
                if (funct3 == 3'b000) begin
                    if (instr == 32'h0000_0073) begin
                        dec.cause = `MCAUSE_ECALLMM;
                        dec.intr = 1'b1;
                        dec.legal = 1'b1;
                    end else if (instr == 32'h0010_0073) begin
                        dec.cause = `MCAUSE_BRKPOINT;
                        dec.intr = 1'b1;
                        dec.legal = 1'b1;
                    end else if (instr == 32'h3020_0073) begin
                        dec.mret = 1'b1;
                        dec.legal = 1'b1;
                    end
                end else begin
                    // Immediate Zicsr forms take rs1 as zimm
                    dec.csr_op = funct3[1:0];
                    dec.operand1 = funct3[2] ? `D_OPR1_ZIMM : `D_OPR1_RS1;
                    dec.operand2 = `D_OPR2_IMM;
                    dec.imm = imm_i;
                    dec.wb_en = 1'b1;
                    dec.legal = (funct3[1:0] != 2'd0);
                end
            end
            default: dec.legal = 1'b0;
        endcase

        // Unknown or malformed words go to the trap pipe
        if (!dec.legal) begin
            dec.op_type = `OT_TRAP;
            dec.cause = `MCAUSE_ILLEGALI;
            dec.intr = 1'b1;
            dec.mret = 1'b0;
        end
    end

endmodule

// File: hdl/dispatch_register.sv
`timescale 1ns/1ns
`include "rv_decode_defines.svh"

module dispatch_register (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    flush,
    input  logic                    fetch_valid,
    input  rv_decode_pkg::decoded_t dec,
    input  rv_decode_pkg::xlen_t    pc,
    output rv_decode_pkg::decoded_t dec_out,
    output rv_decode_pkg::xlen_t    pc_out,
    output logic                    int_valid,
    output logic                    ls_valid,
    output logic                    trap_valid
);

    logic to_int;
    logic to_ls;
    logic to_trap;

    // Pipe selection by class
    assign to_int  = (dec.op_type == `OT_INT) || (dec.op_type == `OT_BRANCH);
    assign to_ls   = (dec.op_type == `OT_LOAD) || (dec.op_type == `OT_STORE) ||
                     (dec.op_type == `OT_FENCE);
    assign to_trap = (dec.op_type == `OT_TRAP);

    always_ff @(posedge clk) begin
        if (fetch_valid) begin
            dec_out <= dec;
            pc_out  <= pc;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            int_valid  <= 1'b0;
            ls_valid   <= 1'b0;
            trap_valid <= 1'b0;
        end else begin
            int_valid  <= fetch_valid && to_int;
            ls_valid   <= fetch_valid && to_ls;
            trap_valid <= fetch_valid && to_trap;
        end
    end

endmodule

// File: hdl/decode_stage.sv
`timescale 1ns/1ns

module decode_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    instr_valid,
    input  logic                    flush,
    input  rv_decode_pkg::fetch_t   fetch_in,
    output rv_decode_pkg::decoded_t dec_out,
    output rv_decode_pkg::xlen_t    pc_out,
    output logic                    int_valid,
    output logic                    ls_valid,
    output logic                    trap_valid
);

    rv_decode_pkg::fetch_t   fetch_q;
    logic                    fetch_valid;
    rv_decode_pkg::decoded_t dec;

    fetch_latch u_fetch_latch (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .flush       (flush),
        .fetch_in    (fetch_in),
        .fetch_q     (fetch_q),
        .fetch_valid (fetch_valid)
    );

    instr_decoder u_instr_decoder (
        .instr (fetch_q.instr),
        .dec   (dec)
    );

    dispatch_register u_dispatch_register (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .fetch_valid (fetch_valid),
        .dec         (dec),
        .pc          (fetch_q.pc),
        .dec_out     (dec_out),
        .pc_out      (pc_out),
        .int_valid   (int_valid),
        .ls_valid    (ls_valid),
        .trap_valid  (trap_valid)
    );

endmodule

// File: tests/tb_decode_stage.sv
`timescale 1ns/1ns
`include "rv_decode_defines.svh"

module tb_decode_stage;

    localparam int INT_COUNT = 40;
    localparam int RAND_COUNT = 100;
    localparam int FIXED_COUNT = 64;
    localparam int TIMEOUT_NS = (INT_COUNT + RAND_COUNT + FIXED_COUNT + 50) * 10;

    // One expected dispatch and the compare cycle it is due in
    typedef struct packed {
        rv_decode_pkg::decoded_t dec;
        rv_decode_pkg::xlen_t    pc;
        logic [2:0]              pipe;
        logic [31:0]             due;
    } expect_t;

    logic                    clk;
    logic                    rst_n;
    logic                    instr_valid;
    logic                    flush;
    rv_decode_pkg::fetch_t   fetch_in;
    rv_decode_pkg::decoded_t dec_out;
    rv_decode_pkg::xlen_t    pc_out;
    logic                    int_valid;
    logic                    ls_valid;
    logic                    trap_valid;

    rv_decode_pkg::xlen_t pc;
    int                   cycle;
    expect_t              exp_q[$];
    string                name_q[$];

    decode_stage uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .flush       (flush),
        .fetch_in    (fetch_in),
        .dec_out     (dec_out),
        .pc_out      (pc_out),
        .int_valid   (int_valid),
        .ls_valid    (ls_valid),
        .trap_valid  (trap_valid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        if (actual !== expected) begin
            $display("Mismatch %s expected %h actual %h", name, expected, actual);
            $display("tests failed");
            $fatal(1, "stopping at first error");
        end
    endtask

    function automatic rv_decode_pkg::xlen_t sign_extend(input logic [63:0] raw, input int top);
        rv_decode_pkg::xlen_t r;
        r = raw;
        for (int i = top + 1; i < 64; i++) begin
            r[i] = raw[top];
        end
        return r;
    endfunction

    // Expected record built from the RV64I decode rules
    function automatic rv_decode_pkg::decoded_t decode_ref(input rv_decode_pkg::instr_t w);
        rv_decode_pkg::decoded_t d;
        rv_decode_pkg::xlen_t    imm_i;
        logic [6:0]              opc;
        logic [6:0]              f7;
        logic [2:0]              f3;
        logic                    ok;
        opc = w[6:0];
        f3 = w[14:12];
        f7 = w[31:25];
        imm_i = sign_extend({52'd0, w[31:20]}, 11);
        d = '0;
        d.rs1 = w[19:15];
        d.rs2 = w[24:20];
        d.rd = w[11:7];
        ok = 1'b0;
        case (opc)
            `OP_LUI, `OP_AUIPC: begin
                d.op_type = `OT_INT;
                d.op = `ALU_ADDSUB;
                d.operand1 = (opc == `OP_LUI) ? `D_OPR1_ZERO : `D_OPR1_PC;
                d.operand2 = `D_OPR2_IMM;
                d.imm = sign_extend({32'd0, w[31:12], 12'd0}, 31);
                d.wb_en = 1'b1;
                ok = 1'b1;
            end
            `OP_INTIMM, `OP_INTIMMW, `OP_INTREG, `OP_INTREGW: begin
                d.op_type = `OT_INT;
                d.op = {1'b0, f3};
                d.truncate = (opc == `OP_INTIMMW) || (opc == `OP_INTREGW);
                d.operand1 = `D_OPR1_RS1;
                d.wb_en = 1'b1;
                if (opc == `OP_INTREG || opc == `OP_INTREGW) begin
                    d.operand2 = `D_OPR2_RS2;
                    d.option = (f3 == 3'b000 || f3 == 3'b101) && f7[5];
                    ok = ((f3 == 3'b000 || f3 == 3'b101) ? (f7 & 7'b1011111) : f7) == 7'd0;
                end else begin
                    d.operand2 = `D_OPR2_IMM;
                    d.imm = imm_i;
                    d.option = (f3 == 3'b101) && f7[5];
                    case (f3)
                        3'b001: ok = d.truncate ? (f7 == 7'd0) : (f7[6:1] == 6'd0);
                        3'b101: ok = ((f7 & (d.truncate ? 7'b1011111 : 7'b1011110)) == 7'd0);
                        default: ok = 1'b1;
                    endcase
                end
                // W forms only have add/sub and the shifts
                if (d.truncate && f3 != 3'b000 && f3 != 3'b001 && f3 != 3'b101) begin
                    ok = 1'b0;
                end
            end
            `OP_JAL, `OP_JALR: begin
                // Both jumps link with PC + 4
                d.op_type = `OT_BRANCH;
                d.op = `ALU_ADDSUB;
                d.operand1 = `D_OPR1_PC;
                d.operand2 = `D_OPR2_4;
                d.wb_en = 1'b1;
                ok = 1'b1;
                if (opc == `OP_JAL) begin
                    d.br_type = `BT_JAL;
                    d.br_base_src = `BB_PC;
                    d.imm = sign_extend({43'd0, w[31], w[19:12], w[20], w[30:21], 1'b0}, 20);
                end else begin
                    d.br_type = `BT_JALR;
                    d.br_base_src = `BB_RS1;
                    d.br_inj_pc = 1'b1;
                    d.imm = imm_i;
                end
            end
            `OP_BRANCH: begin
                d.op_type = `OT_BRANCH;
                d.br_type = `BT_BCOND;
                d.br_base_src = `BB_PC;
                d.operand1 = `D_OPR1_RS1;
                d.operand2 = `D_OPR2_RS2;
                d.imm = sign_extend({51'd0, w[31], w[7], w[30:25], w[11:8], 1'b0}, 12);
                ok = (f3[2:1] != 2'b01);
                if (ok) begin
                    d.br_neg = f3[0];
                    d.op = (f3[2:1] == 2'b00) ? `ALU_EQ : (f3[1] ? `ALU_SLTU : `ALU_SLT);
                end
            end
            `OP_LOAD, `OP_STORE: begin
                d.mem_sign = f3[2];
                d.mem_width = f3[1:0];
                d.operand1 = `D_OPR1_RS1;
                if (opc == `OP_LOAD) begin
                    d.op_type = `OT_LOAD;
                    d.operand2 = `D_OPR2_IMM;
                    d.imm = imm_i;
                    d.wb_en = 1'b1;
                    ok = (f3 != 3'b111);
                end else begin
                    d.op_type = `OT_STORE;
                    d.operand2 = `D_OPR2_RS2;
                    d.imm = sign_extend({52'd0, w[31:25], w[11:7]}, 11);
                    ok = !f3[2];
                end
            end
            `OP_FENCE: begin
                d.op_type = `OT_FENCE;
                if (w == 32'h0000_100f) begin
                    d.fencei = 1'b1;
                    ok = 1'b1;
                end else begin
                    ok = (w[31:28] == 4'd0) && (w[19:7] == 13'd0);
                end
            end
            `OP_ENVCSR: begin
                d.op_type = `OT_TRAP;
                if (f3 == 3'b000) begin
                    case (w)
                        32'h0000_0073: {d.cause, d.intr, ok} = {`MCAUSE_ECALLMM, 2'b11};
                        32'h0010_0073: {d.cause, d.intr, ok} = {`MCAUSE_BRKPOINT, 2'b11};
                        32'h3020_0073: {d.mret, ok} = 2'b11;
                        default: ok = 1'b0;
                    endcase
                end else begin
                    d.csr_op = f3[1:0];
                    d.operand1 = f3[2] ? `D_OPR1_ZIMM : `D_OPR1_RS1;
                    d.operand2 = `D_OPR2_IMM;
                    d.imm = imm_i;
                    d.wb_en = 1'b1;
                    ok = (f3[1:0] != 2'd0);
                end
            end
            default: ok = 1'b0;
        endcase
        d.legal = ok;
        if (!ok) begin
            d.op_type = `OT_TRAP;
            d.cause = `MCAUSE_ILLEGALI;
            d.intr = 1'b1;
            d.mret = 1'b0;
        end
        return d;
    endfunction

    // Strobe order is {trap, ls, int}
    function automatic logic [2:0] pipe_of(input rv_decode_pkg::op_class_t t);
        case (t)
            `OT_INT, `OT_BRANCH: return 3'b001;
            `OT_LOAD, `OT_STORE, `OT_FENCE: return 3'b010;
            `OT_TRAP: return 3'b100;
            default: return 3'b000;
        endcase
    endfunction

    // Legal OP, OP-IMM and W-form words with random fields
    function automatic rv_decode_pkg::instr_t random_int_word();
        logic [31:0] r;
        logic [31:0] s;
        logic [6:0]  f7;
        logic [6:0]  opc;
        logic [2:0]  f3;
        r = $urandom;
        s = $urandom;
        f3 = r[14:12];
        f7 = r[31:25];
        case (s[1:0])
            2'd0: begin
                opc = `OP_INTIMM;
                if (f3 == 3'b001) begin
                    f7 = {6'd0, s[2]};
                end else if (f3 == 3'b101) begin
                    f7 = {1'b0, s[3], 4'd0, s[2]};
                end
            end
            2'd1: begin
                opc = `OP_INTREG;
                f7 = (f3 == 3'b000 || f3 == 3'b101) ? {1'b0, s[3], 5'd0} : 7'd0;
            end
            default: begin
                opc = s[0] ? `OP_INTREGW : `OP_INTIMMW;
                f3 = (s[5:4] == 2'd0) ? 3'b000 : ((s[5:4] == 2'd1) ? 3'b001 : 3'b101);
                if (f3 == 3'b001) begin
                    f7 = 7'd0;
                end else if (f3 == 3'b101 || s[0]) begin
                    f7 = {1'b0, s[3], 5'd0};
                end
            end
        endcase
        return {f7, r[24:15], f3, r[11:7], opc};
    endfunction

    task automatic issue(input string name, input rv_decode_pkg::instr_t word);
        expect_t e;
        @(negedge clk);
        fetch_in.instr = word;
        fetch_in.pc = pc;
        instr_valid = 1'b1;
        e.dec = decode_ref(word);
        e.pc = pc;
        e.pipe = pipe_of(e.dec.op_type);
        e.due = 32'(cycle + 2);
        exp_q.push_back(e);
        name_q.push_back(name);
        pc = pc + 64'd4;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            instr_valid = 1'b0;
        end
    endtask

    // A flush with a word offered in the same cycle drops everything not yet dispatched
    task automatic flush_with(input rv_decode_pkg::instr_t word);
        @(negedge clk);
        flush = 1'b1;
        instr_valid = 1'b1;
        fetch_in.instr = word;
        fetch_in.pc = pc;
        while (exp_q.size() > 0 && exp_q[$].due > 32'(cycle)) begin
            void'(exp_q.pop_back());
            void'(name_q.pop_back());
        end
        @(negedge clk);
        flush = 1'b0;
        instr_valid = 1'b0;
    endtask

    // Compare just after each rising edge
    initial begin
        expect_t    e;
        string      nm;
        logic [2:0] actual;
        cycle = 0;
        forever begin
            @(posedge clk);
            #1;
            cycle++;
            if (cycle > 2) begin
                actual = {trap_valid, ls_valid, int_valid};
                if (exp_q.size() > 0 && exp_q[0].due == 32'(cycle)) begin
                    e = exp_q.pop_front();
                    nm = name_q.pop_front();
                    check_value({nm, " strobe"}, 128'(e.pipe), 128'(actual));
                    check_value({nm, " record"}, 128'(e.dec), 128'(dec_out));
                    check_value({nm, " pc"}, 128'(e.pc), 128'(pc_out));
                end else begin
                    check_value("idle strobes", 128'(3'b000), 128'(actual));
                end
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout after %0d ns with %0d dispatches outstanding", TIMEOUT_NS,
                 exp_q.size());
        $display("tests failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        logic [31:0] r;
        void'($urandom(32'hfb93));
        rst_n = 1'b0;
        instr_valid = 1'b0;
        flush = 1'b0;
        fetch_in = '0;
        pc = 64'hffff_ffff_8000_0000;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        idle(2);

        // Integer group issued back to back
        issue("lui", {20'hfffff, 5'd1, `OP_LUI});
        issue("auipc", {20'h12345, 5'd2, `OP_AUIPC});
        for (int i = 0; i < INT_COUNT; i++) begin
            issue("int random", random_int_word());
        end
        idle(2);

        // Jumps and branches with alternating offset sign
        for (int i = 0; i < 4; i++) begin
            r = $urandom;
            r[31] = i[0];
            issue("jal", {r[31:7], `OP_JAL});
            r = $urandom;
            r[31] = !i[0];
            issue("jalr", {r[31:7], `OP_JALR});
        end
        for (int i = 0; i < 8; i++) begin
            if (i != 2 && i != 3) begin
                r = $urandom;
                issue("branch neg", {1'b1, r[30:15], 3'(i), r[11:7], `OP_BRANCH});
                r = $urandom;
                issue("branch pos", {1'b0, r[30:15], 3'(i), r[11:7], `OP_BRANCH});
            end
        end
        idle(1);

        for (int i = 0; i < 7; i++) begin
            r = $urandom;
            issue("load", {r[31:15], 3'(i), r[11:7], `OP_LOAD});
        end
        for (int i = 0; i < 4; i++) begin
            r = $urandom;
            issue("store", {r[31:15], 3'(i), r[11:7], `OP_STORE});
        end
        issue("fence", 32'h0ff0_000f);
        issue("fence.i", 32'h0000_100f);

        issue("ecall", 32'h0000_0073);
        issue("ebreak", 32'h0010_0073);
        issue("mret", 32'h3020_0073);
        for (int i = 1; i < 8; i++) begin
            if (i != 4) begin
                r = $urandom;
                issue("csr", {r[31:15], 3'(i), r[11:7], `OP_ENVCSR});
            end
        end
        idle(1);

        issue("bad slli funct7", {7'b0100000, 5'd3, 5'd4, 3'b001, 5'd5, `OP_INTIMM});
        issue("bad srai funct7", {7'b1000000, 5'd3, 5'd4, 3'b101, 5'd5, `OP_INTIMM});
        issue("mulw", {7'b0000001, 5'd6, 5'd7, 3'b000, 5'd8, `OP_INTREGW});
        issue("branch funct3 2", {7'd0, 5'd1, 5'd2, 3'b010, 5'd0, `OP_BRANCH});
        issue("load funct3 7", {12'h010, 5'd2, 3'b111, 5'd3, `OP_LOAD});
        issue("csr funct3 4", {12'h300, 5'd2, 3'b100, 5'd3, `OP_ENVCSR});
        for (int i = 0; i < RAND_COUNT; i++) begin
            issue("random word", $urandom);
        end
        idle(2);

        // Flush lands with one word in the latch and one offered alongside
        issue("before flush", random_int_word());
        issue("in flight", random_int_word());
        issue("in fetch", random_int_word());
        flush_with(random_int_word());
        for (int i = 0; i < 4; i++) begin
            issue("after flush", random_int_word());
        end
        idle(1);

        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        idle(4);
        $display("all tests passed");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+hdl
hdl/rv_decode_pkg.sv
hdl/fetch_latch.sv
hdl/instr_decoder.sv
hdl/dispatch_register.sv
hdl/decode_stage.sv
tests/tb_decode_stage.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_decode_stage
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= all tests passed
VFLAGS    ?= --binary --timing -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
